// ==== fetch_pkg.sv ====
// Shared fetch constants; XLEN fixed at 32, OFFSET 2 assumes no compressed instructions
package fetch_pkg;

  // ------------------------------
  // Datapath widths
  // ------------------------------

  // Address and data word width
  localparam int XLEN = 32;

  // Always-zero low PC bits
  // Fixed at 2 because every fetch address is word aligned
  localparam int OFFSET = 2;

  // Sequential fetch increment in bytes
  localparam logic [XLEN-1:0] ILEN_BYTES = 32'd4;

  // ------------------------------
  // Reset state
  // ------------------------------

  // First fetch address after reset
  localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_1000;

  // ------------------------------
  // Direction counters
  // ------------------------------

  // Bimodal 2-bit saturating counter
  typedef logic [1:0] bht_cnt_t;

  // Strongly not taken, lower saturation point
  localparam bht_cnt_t SNT = 2'd0;

  // Weakly not taken, value after reset
  localparam bht_cnt_t WNT = 2'd1;

  // Weakly taken
  localparam bht_cnt_t WT = 2'd2;

  // Strongly taken, upper saturation point
  localparam bht_cnt_t ST = 2'd3;

  // Upper bit set means predict taken
  // WT and ST predict taken, SNT and WNT do not
  // A single wrong outcome from a strong state keeps the prediction
  // Two wrong outcomes in a row flip it

endpackage

// ==== btb.sv ====
// Direct-mapped BTB; stores target without its OFFSET bits, entry kept only for taken branches
module btb #(
  parameter int BTB_BITS = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         flush_i,
  input  logic [fetch_pkg::XLEN-1:0]                   curr_pc_i,
  input  logic                                         res_valid_i,
  input  logic                                         res_taken_i,
  input  logic [fetch_pkg::XLEN-1:0]                   res_pc_i,
  input  logic [fetch_pkg::XLEN-1:0]                   res_target_i,
  output logic                                         hit_o,
  output logic [fetch_pkg::XLEN-fetch_pkg::OFFSET-1:0] target_o
);
  import fetch_pkg::*;

  // Number of entries
  localparam int BTB_ROWS = 1 << BTB_BITS;
  // Tag is everything above index and offset
  localparam int TAG_W = XLEN - BTB_BITS - OFFSET;

  // Entry storage, split into control and payload
  logic                   valid_q  [BTB_ROWS];
  logic [TAG_W-1:0]       tag_q    [BTB_ROWS];
  logic [XLEN-OFFSET-1:0] target_q [BTB_ROWS];

  // Read and write address fields
  logic [BTB_BITS-1:0] idx_r;
  logic [BTB_BITS-1:0] idx_w;
  logic [TAG_W-1:0]    tag_r;
  logic [TAG_W-1:0]    tag_w;

  // ------------------------------
  // Update from resolution
  // ------------------------------

  // Index and tag of the resolved branch
  assign idx_w = res_pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign tag_w = res_pc_i[XLEN-1:BTB_BITS+OFFSET];

  // Valid bits
  // Flush wins over a write in the same cycle
  // Taken resolution allocates, not taken deletes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < BTB_ROWS; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (flush_i) begin
      for (int i = 0; i < BTB_ROWS; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (res_valid_i) begin
      valid_q[idx_w] <= res_taken_i;
    end
  end

  // Tag and target, only meaningful while valid is set
  // Written on every taken resolution, a stale payload is harmless
  always_ff @(posedge clk_i) begin
    if (res_valid_i && res_taken_i) begin
      tag_q[idx_w]    <= tag_w;
      target_q[idx_w] <= res_target_i[XLEN-1:OFFSET];
    end
  end

  // ------------------------------
  // Lookup by fetch PC
  // ------------------------------

  // Index and tag of the current fetch address
  assign idx_r = curr_pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign tag_r = curr_pc_i[XLEN-1:BTB_BITS+OFFSET];

  // Hit needs a valid entry with a matching tag
  // Aliased PCs share an index but fail the tag compare
  assign hit_o = valid_q[idx_r] & (tag_q[idx_r] == tag_r);

  // Target is passed on unqualified, the consumer gates it with hit
  assign target_o = target_q[idx_r];

endmodule

// ==== bht.sv ====
// Bimodal table indexed by PC bits above OFFSET; no tags, so aliased branches share a counter
module bht #(
  parameter int BHT_BITS = 6
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [fetch_pkg::XLEN-1:0] curr_pc_i,
  input  logic [fetch_pkg::XLEN-1:0] res_pc_i,
  input  logic                       res_valid_i,
  input  logic                       res_taken_i,
  output logic                       taken_o
);
  import fetch_pkg::*;

  // Number of counters
  localparam int BHT_ROWS = 1 << BHT_BITS;

  // Position of the direction bit inside a counter
  localparam int DIR_BIT = $bits(bht_cnt_t) - 1;

  // Counter storage
  bht_cnt_t cnt_q [BHT_ROWS];

  // Read and write indexes
  logic [BHT_BITS-1:0] idx_r;
  logic [BHT_BITS-1:0] idx_w;

  // Current and next value of the trained counter
  bht_cnt_t cnt_old;
  bht_cnt_t cnt_new;

  // ------------------------------
  // Training
  // ------------------------------

  // Counter addressed by the resolved branch
  assign idx_w   = res_pc_i[BHT_BITS+OFFSET-1:OFFSET];
  assign cnt_old = cnt_q[idx_w];

  // Saturating step toward the resolved direction
  always_comb begin
    // Hold by default, covers both saturation points
    cnt_new = cnt_old;
    if (res_taken_i) begin
      // Count up, stop at strongly taken
      if (cnt_old != ST) begin
        cnt_new = cnt_old + 2'd1;
      end
    end else begin
      // Count down, stop at strongly not taken
      if (cnt_old != SNT) begin
        cnt_new = cnt_old - 2'd1;
      end
    end
  end

  // Counter array
  // All counters start weakly not taken
  // Only the addressed counter changes on a resolution
  // Not cleared by flush, direction history survives it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < BHT_ROWS; i++) begin
        cnt_q[i] <= WNT;
      end
    end else if (res_valid_i) begin
      cnt_q[idx_w] <= cnt_new;
    end
  end

  // ------------------------------
  // Prediction
  // ------------------------------

  // Counter addressed by the fetch PC
  assign idx_r = curr_pc_i[BHT_BITS+OFFSET-1:OFFSET];

  // Predict taken on WT and ST
  // Same-cycle training is not forwarded, the old value is read
  assign taken_o = cnt_q[idx_r][DIR_BIT];

endmodule

// ==== pc_gen.sv ====
// Fetch PC register; redirect target is taken as given and assumed word aligned
module pc_gen (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         fetch_ready_i,
  input  logic                                         btb_hit_i,
  input  logic                                         bht_taken_i,
  input  logic [fetch_pkg::XLEN-fetch_pkg::OFFSET-1:0] btb_target_i,
  input  logic                                         res_valid_i,
  input  logic                                         res_mispredict_i,
  input  logic                                         res_taken_i,
  input  logic [fetch_pkg::XLEN-1:0]                   res_pc_i,
  input  logic [fetch_pkg::XLEN-1:0]                   res_target_i,
  output logic [fetch_pkg::XLEN-1:0]                   pc_o,
  output logic [fetch_pkg::XLEN-1:0]                   pred_target_o,
  output logic                                         pred_taken_o
);
  import fetch_pkg::*;

  // Fetch PC register
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_d;

  // Sequential successor of the fetch PC
  logic [XLEN-1:0] seq_pc;

  // BTB target widened back to a full address
  logic [XLEN-1:0] btb_pc;

  // Redirect request and its address
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;

  // ------------------------------
  // Prediction
  // ------------------------------

  // Next word in program order
  assign seq_pc = pc_q + ILEN_BYTES;

  // Dropped offset bits are always zero
  assign btb_pc = {btb_target_i, {OFFSET{1'b0}}};

  // Taken only when the BTB knows the target and the counter agrees
  // A BTB hit with a not-taken counter falls through to PC + 4
  assign pred_taken_o = btb_hit_i & bht_taken_i;

  // Predicted successor of the current fetch PC
  assign pred_target_o = pred_taken_o ? btb_pc : seq_pc;

  // ------------------------------
  // Redirect from execute
  // ------------------------------

  // Only a mispredicted resolution steers fetch
  // Correct resolutions train the tables and nothing more
  assign redirect = res_valid_i & res_mispredict_i;

  // Actual successor of the resolved branch
  // Taken goes to the resolved target, not taken to the next word
  assign redirect_pc = res_taken_i ? res_target_i : (res_pc_i + ILEN_BYTES);

  // ------------------------------
  // Next PC
  // ------------------------------

  // Priority order
  // 1. Mispredict redirect, also while stalled
  // 2. Stall holds the current PC
  // 3. Predicted successor
  always_comb begin
    if (redirect) begin
      pc_d = redirect_pc;
    end else if (!fetch_ready_i) begin
      pc_d = pc_q;
    end else begin
      pc_d = pred_target_o;
    end
  end

  // PC register, starts at the boot address
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= BOOT_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  // Registered fetch address to the tables and the fetch port
  assign pc_o = pc_q;

endmodule

// ==== fetch_predictor.sv ====
// Next-PC prediction top; no handshakes, resolutions are single-cycle strobes used on arrival
module fetch_predictor #(
  parameter int BTB_BITS = 4,
  parameter int BHT_BITS = 6
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  logic                       fetch_ready_i,
  input  logic                       res_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] res_pc_i,
  input  logic [fetch_pkg::XLEN-1:0] res_target_i,
  input  logic                       res_taken_i,
  input  logic                       res_mispredict_i,
  output logic [fetch_pkg::XLEN-1:0] pc_o,
  output logic                       pred_taken_o,
  output logic [fetch_pkg::XLEN-1:0] pred_target_o
);
  import fetch_pkg::*;

  // Fetch PC shared by both lookups
  logic [XLEN-1:0] curr_pc;

  // BTB lookup result
  logic                   btb_hit;
  logic [XLEN-OFFSET-1:0] btb_target;

  // Direction lookup result
  logic bht_taken;

  // ------------------------------
  // PC generator
  // ------------------------------
  pc_gen u_pc_gen (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .fetch_ready_i    (fetch_ready_i),
    .btb_hit_i        (btb_hit),
    .bht_taken_i      (bht_taken),
    .btb_target_i     (btb_target),
    .res_valid_i      (res_valid_i),
    .res_mispredict_i (res_mispredict_i),
    .res_taken_i      (res_taken_i),
    .res_pc_i         (res_pc_i),
    .res_target_i     (res_target_i),
    .pc_o             (curr_pc),
    .pred_target_o    (pred_target_o),
    .pred_taken_o     (pred_taken_o)
  );

  assign pc_o = curr_pc;

  // Target buffer, cleared by flush
  btb #(
    .BTB_BITS (BTB_BITS)
  ) u_btb (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .curr_pc_i    (curr_pc),
    .res_valid_i  (res_valid_i),
    .res_taken_i  (res_taken_i),
    .res_pc_i     (res_pc_i),
    .res_target_i (res_target_i),
    .hit_o        (btb_hit),
    .target_o     (btb_target)
  );

  // Direction counters, kept across flush
  bht #(
    .BHT_BITS (BHT_BITS)
  ) u_bht (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .curr_pc_i   (curr_pc),
    .res_pc_i    (res_pc_i),
    .res_valid_i (res_valid_i),
    .res_taken_i (res_taken_i),
    .taken_o     (bht_taken)
  );

endmodule

// ==== tb_clock.sv ====
// Testbench clock and reset; 4 ns period, reset released 1 ns after the last held edge
module tb_clock #(
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free-running clock, 2 ns per phase
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset low for RESET_CYCLES rising edges
  // Release lands off the edge so the first active edge is clean
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== tb_fetch_predictor.sv ====
// Directed testbench for BTB_BITS 4 and BHT_BITS 6 with a reference model of both tables
module tb_fetch_predictor;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  // Table sizes handed to the DUT
  localparam int BTB_BITS = 4;
  localparam int BHT_BITS = 6;
  localparam int BTB_ROWS = 1 << BTB_BITS;
  localparam int BHT_ROWS = 1 << BHT_BITS;

  // Cycle budget per test, used by the watchdog
  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES = 11;
  localparam int T1_CYCLES = 20;
  localparam int T2_CYCLES = 24;
  localparam int T3_CYCLES = 13;
  localparam int T4_CYCLES = 4;
  localparam int T5_CYCLES = 7;
  localparam int T6_CYCLES = 23;
  localparam int WATCHDOG_NS = (RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES +
                                T4_CYCLES + T5_CYCLES + T6_CYCLES) * CLK_PERIOD_NS * 2;

  logic            clk;
  logic            rst_n;
  logic            flush_i;
  logic            fetch_ready_i;
  logic            res_valid_i;
  logic [XLEN-1:0] res_pc_i;
  logic [XLEN-1:0] res_target_i;
  logic            res_taken_i;
  logic            res_mispredict_i;
  logic [XLEN-1:0] pc_o;
  logic            pred_taken_o;
  logic [XLEN-1:0] pred_target_o;

  // Reference model state
  logic [XLEN-1:0] m_pc;
  logic            m_valid [BTB_ROWS];
  logic [XLEN-1:0] m_tag   [BTB_ROWS];
  logic [XLEN-1:0] m_tgt   [BTB_ROWS];
  int              m_cnt   [BHT_ROWS];

  // Branch pairs shared by the tests
  logic [XLEN-1:0] br_pc  [8];
  logic [XLEN-1:0] br_tgt [8];

  int errors;
  int checks;
  int tests;
  int test_errors;
  int test_checks;

  tb_clock u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fetch_predictor #(
    .BTB_BITS (BTB_BITS),
    .BHT_BITS (BHT_BITS)
  ) i_dut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .flush_i          (flush_i),
    .fetch_ready_i    (fetch_ready_i),
    .res_valid_i      (res_valid_i),
    .res_pc_i         (res_pc_i),
    .res_target_i     (res_target_i),
    .res_taken_i      (res_taken_i),
    .res_mispredict_i (res_mispredict_i),
    .pc_o             (pc_o),
    .pred_taken_o     (pred_taken_o),
    .pred_target_o    (pred_target_o)
  );

  // ------------------------------
  // Reference model
  // ------------------------------

  // Valid entry whose tag matches the upper PC bits
  function automatic logic model_hit(input logic [XLEN-1:0] pc);
    int idx;
    idx = (pc >> OFFSET) % BTB_ROWS;
    return m_valid[idx] && (m_tag[idx] == (pc >> (OFFSET + BTB_BITS)));
  endfunction

  // Counter at WT or above predicts taken
  function automatic logic model_taken(input logic [XLEN-1:0] pc);
    int idx;
    idx = (pc >> OFFSET) % BHT_ROWS;
    return m_cnt[idx] >= 2;
  endfunction

  function automatic logic [XLEN-1:0] model_target(input logic [XLEN-1:0] pc);
    int idx;
    idx = (pc >> OFFSET) % BTB_ROWS;
    if (model_hit(pc) && model_taken(pc)) begin
      return m_tgt[idx];
    end
    return pc + 32'd4;
  endfunction

  task automatic check_word(input string name, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
    checks++;
    test_checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("FAILED @ %0d ns: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
    end
  endtask

  // One clock with the given inputs and the model stepped alongside the DUT
  task automatic run_cycle(input logic flush, input logic ready, input logic valid,
                           input logic taken, input logic mispredict,
                           input logic [XLEN-1:0] pc, input logic [XLEN-1:0] target);
    logic [XLEN-1:0] next_pc;
    int              bi;
    int              ci;
    flush_i          = flush;
    fetch_ready_i    = ready;
    res_valid_i      = valid;
    res_taken_i      = taken;
    res_mispredict_i = mispredict;
    res_pc_i         = pc;
    res_target_i     = target;
    // Next PC from the old table state
    // Redirect first, then stall, then prediction
    if (valid && mispredict) begin
      next_pc = taken ? target : pc + 32'd4;
    end else if (!ready) begin
      next_pc = m_pc;
    end else begin
      next_pc = model_target(m_pc);
    end
    @(posedge clk);
    bi = (pc >> OFFSET) % BTB_ROWS;
    ci = (pc >> OFFSET) % BHT_ROWS;
    // Flush beats a write in the same cycle
    if (flush) begin
      for (int i = 0; i < BTB_ROWS; i++) begin
        m_valid[i] = 1'b0;
      end
    end else if (valid) begin
      m_valid[bi] = taken;
      if (taken) begin
        m_tag[bi] = pc >> (OFFSET + BTB_BITS);
        m_tgt[bi] = target & 32'hFFFF_FFFC;
      end
    end
    // Counters train even on a flush cycle
    if (valid) begin
      if (taken && m_cnt[ci] < 3) begin
        m_cnt[ci]++;
      end else if (!taken && m_cnt[ci] > 0) begin
        m_cnt[ci]--;
      end
    end
    m_pc = next_pc;
    #1;
    flush_i          = 1'b0;
    res_valid_i      = 1'b0;
    res_mispredict_i = 1'b0;
    check_word("pc_o", m_pc, pc_o);
    check_word("pred_taken_o", model_hit(m_pc) && model_taken(m_pc), pred_taken_o);
    check_word("pred_target_o", model_target(m_pc), pred_target_o);
  endtask

  task automatic idle_cycle(input logic ready);
    run_cycle(1'b0, ready, 1'b0, 1'b0, 1'b0, '0, '0);
  endtask

  // Correctly predicted resolution that only trains
  task automatic resolve(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] target,
                         input logic taken);
    run_cycle(1'b0, 1'b1, 1'b1, taken, 1'b0, pc, target);
  endtask

  // Not-taken mispredict on the word before lands fetch on target_pc
  task automatic steer_to(input logic [XLEN-1:0] target_pc);
    run_cycle(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, target_pc - 32'd4, '0);
    check_word("pc_o", target_pc, pc_o);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("[%0d ns] %s: %0d checks, %0d errors", $time, name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  // ------------------------------
  // Tests
  // ------------------------------

  task automatic test_reset_seq();
    check_word("pc_o", BOOT_PC, pc_o);
    check_word("pred_taken_o", 1'b0, pred_taken_o);
    for (int i = 1; i <= T1_CYCLES; i++) begin
      idle_cycle(1'b1);
      check_word("pc_o", BOOT_PC + 32'(4 * i), pc_o);
    end
    end_test("reset and sequential fetch");
  endtask

  task automatic test_train_taken();
    // Even BTB index per pair keeps the steering word before each one at an odd index
    for (int k = 0; k < 8; k++) begin
      br_pc[k]  = ($urandom & 32'hFFFF_FFC0) | 32'((2 * k) << OFFSET);
      br_tgt[k] = $urandom & 32'hFFFF_FFFC;
    end
    for (int k = 0; k < 8; k++) begin
      resolve(br_pc[k], br_tgt[k], 1'b1);
      steer_to(br_pc[k]);
      check_word("pred_taken_o", 1'b1, pred_taken_o);
      check_word("pred_target_o", br_tgt[k], pred_target_o);
      idle_cycle(1'b1);
      check_word("pc_o", br_tgt[k], pc_o);
    end
    end_test("training to taken");
  endtask

  task automatic test_not_taken_delete();
    // Counter walks ST, WT, ST, then down to SNT and back to WNT
    resolve(br_pc[0], br_tgt[0], 1'b1);
    resolve(br_pc[0], br_tgt[0], 1'b0);
    // Counter is still WT here and only the deleted entry forces PC + 4
    steer_to(br_pc[0]);
    check_word("pred_taken_o", 1'b0, pred_taken_o);
    check_word("pred_target_o", br_pc[0] + 32'd4, pred_target_o);
    repeat (2) resolve(br_pc[0], br_tgt[0], 1'b1);
    steer_to(br_pc[0]);
    check_word("pred_taken_o", 1'b1, pred_taken_o);
    check_word("pred_target_o", br_tgt[0], pred_target_o);
    // Fourth not-taken holds at SNT
    repeat (4) resolve(br_pc[0], br_tgt[0], 1'b0);
    resolve(br_pc[0], br_tgt[0], 1'b1);
    steer_to(br_pc[0]);
    check_word("pred_taken_o", 1'b0, pred_taken_o);
    check_word("pred_target_o", br_pc[0] + 32'd4, pred_target_o);
    idle_cycle(1'b1);
    check_word("pc_o", br_pc[0] + 32'd4, pc_o);
    end_test("not-taken deletes entry");
  endtask

  task automatic test_mispredict();
    logic [XLEN-1:0] rpc;
    logic [XLEN-1:0] rtgt;
    // Odd index keeps the trained pairs untouched
    rpc  = ($urandom & 32'hFFFF_FFF0) | 32'h4;
    rtgt = $urandom & 32'hFFFF_FFFC;
    run_cycle(1'b0, 1'b1, 1'b1, 1'b1, 1'b1, rpc, rtgt);
    check_word("pc_o", rtgt, pc_o);
    run_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, rpc, rtgt);
    check_word("pc_o", rpc + 32'd4, pc_o);
    rpc  = ($urandom & 32'hFFFF_FFF0) | 32'hC;
    rtgt = $urandom & 32'hFFFF_FFFC;
    run_cycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, rpc, rtgt);
    check_word("pc_o", rtgt, pc_o);
    idle_cycle(1'b0);
    check_word("pc_o", rtgt, pc_o);
    end_test("mispredict redirect");
  endtask

  task automatic test_stall();
    logic [XLEN-1:0] new_tgt;
    new_tgt = br_tgt[1] ^ 32'h0000_0100;
    steer_to(br_pc[1]);
    idle_cycle(1'b0);
    check_word("pc_o", br_pc[1], pc_o);
    // Retarget the branch while fetch sits on it
    run_cycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, br_pc[1], new_tgt);
    check_word("pc_o", br_pc[1], pc_o);
    repeat (3) begin
      idle_cycle(1'b0);
      check_word("pc_o", br_pc[1], pc_o);
    end
    check_word("pred_taken_o", 1'b1, pred_taken_o);
    check_word("pred_target_o", new_tgt, pred_target_o);
    idle_cycle(1'b1);
    check_word("pc_o", new_tgt, pc_o);
    br_tgt[1] = new_tgt;
    end_test("stall");
  endtask

  task automatic test_flush_alias();
    logic [XLEN-1:0] pc_a;
    logic [XLEN-1:0] pc_b;
    logic [XLEN-1:0] tgt_b;
    // Pair 2 counter down to SNT where a counter reset would leave WNT
    repeat (2) resolve(br_pc[2], br_tgt[2], 1'b0);
    // Flush with a taken write to pair 5 in the same cycle
    run_cycle(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, br_pc[5], br_tgt[5]);
    for (int k = 0; k < 8; k++) begin
      steer_to(br_pc[k]);
      check_word("pred_taken_o", 1'b0, pred_taken_o);
      check_word("pred_target_o", br_pc[k] + 32'd4, pred_target_o);
    end
    resolve(br_pc[2], br_tgt[2], 1'b1);
    resolve(br_pc[3], br_tgt[3], 1'b1);
    steer_to(br_pc[2]);
    check_word("pred_taken_o", 1'b0, pred_taken_o);
    idle_cycle(1'b1);
    check_word("pc_o", br_pc[2] + 32'd4, pc_o);
    steer_to(br_pc[3]);
    check_word("pred_taken_o", 1'b1, pred_taken_o);
    idle_cycle(1'b1);
    check_word("pc_o", br_tgt[3], pc_o);
    // Same BTB and BHT index with the tag differing in bit 8
    pc_a  = br_pc[4];
    pc_b  = pc_a ^ 32'h0000_0100;
    tgt_b = br_tgt[4] ^ 32'h0000_0080;
    resolve(pc_a, br_tgt[4], 1'b1);
    steer_to(pc_b);
    check_word("pred_taken_o", 1'b0, pred_taken_o);
    resolve(pc_b, tgt_b, 1'b1);
    steer_to(pc_a);
    check_word("pred_taken_o", 1'b0, pred_taken_o);
    steer_to(pc_b);
    check_word("pred_taken_o", 1'b1, pred_taken_o);
    idle_cycle(1'b1);
    check_word("pc_o", tgt_b, pc_o);
    end_test("flush and aliasing");
  endtask

  // ------------------------------
  // Sequence and watchdog
  // ------------------------------

  initial begin
    void'($urandom(91));
    flush_i          = 1'b0;
    fetch_ready_i    = 1'b1;
    res_valid_i      = 1'b0;
    res_pc_i         = '0;
    res_target_i     = '0;
    res_taken_i      = 1'b0;
    res_mispredict_i = 1'b0;
    // Model reset state with empty tables and WNT counters
    m_pc = BOOT_PC;
    for (int i = 0; i < BTB_ROWS; i++) begin
      m_valid[i] = 1'b0;
      m_tag[i]   = '0;
      m_tgt[i]   = '0;
    end
    for (int i = 0; i < BHT_ROWS; i++) begin
      m_cnt[i] = 1;
    end
    wait (rst_n == 1'b1);
    test_reset_seq();
    test_train_taken();
    test_not_taken_delete();
    test_mispredict();
    test_stall();
    test_flush_alias();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== fetch_predictor.f ====
fetch_pkg.sv
btb.sv
bht.sv
pc_gen.sv
fetch_predictor.sv
tb_clock.sv
tb_fetch_predictor.sv
